// File: Makefile
VERILATOR ?= verilator
TOP       ?= wb_stage_tb
FILELIST  ?= wb_stage_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -qF '*** PASSED ***' $(LOG); then echo "no result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD = 20       // ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2);
            clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: wb_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module wb_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              valid_in,
    input  logic              mem_ld,      // raw request before acceptance
    input  logic              full,
    input  logic              is_halt,
    input  logic              ie_val,
    input  logic              ie_ack,
    output logic              stall,
    output logic              accept,
    output logic              halted,
    output wb_pkg::wb_state_t state
);
    import wb_pkg::*;

    wb_state_t state_nxt;
    logic      running;

    assign running = (state == WB_RUN);
    assign stall   = running & valid_in & mem_ld & full;
    assign accept  = running & valid_in & ~stall;
    assign halted  = (state == WB_HALTED);

    always_comb begin
        state_nxt = state;
        case (state)
            WB_RUN: begin
                // exception wins over a faulting hlt
                if (accept && ie_val) begin
                    state_nxt = WB_FAULT;
                end else if (accept && is_halt) begin
                    state_nxt = WB_HALTED;
                end
            end
            WB_FAULT: begin
                if (ie_ack) begin
                    state_nxt = WB_RUN;
                end
            end
            WB_HALTED: begin
                state_nxt = WB_HALTED;      // only reset leaves
            end
            default: begin
                state_nxt = WB_RUN;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= WB_RUN;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

`default_nettype wire

// File: wb_params.svh
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

// result operands per instruction
`define WB_NUM_OPS 4

// write-back address queue
`define WBAQ_DEPTH 4
`define WBAQ_PTR_W 2

// field widths
`define WB_DATA_W 64
`define WB_ADDR_W 32
`define WB_SIZE_W 2
`define WB_RID_W  3      // register / segment id within dest
`define WB_IE_W   4

`endif

// File: wb_pkg.sv
`default_nettype none

`include "wb_params.svh"

package wb_pkg;

    // operand word read as a far pointer (ljmp / lcall / iret)
    typedef struct packed {
        logic [15:0] pad;
        logic [15:0] sel;                   // new cs
        logic [31:0] offset;                // new eip
    } wb_far_ptr_t;

    typedef union packed {
        logic [`WB_DATA_W-1:0] raw;
        wb_far_ptr_t           far;
    } wb_data_u;

    typedef struct packed {
        wb_data_u              data;
        logic [`WB_ADDR_W-1:0] dest;        // reg id, seg id or mem address
        logic                  is_reg;
        logic                  is_seg;
        logic                  is_mem;
        logic                  wb;          // operand is actually written back
    } wb_operand_t;

    typedef struct packed {
        logic [`WB_ADDR_W-1:0] addr;
        logic [`WB_DATA_W-1:0] data;
        logic [`WB_SIZE_W-1:0] size;
    } wbaq_entry_t;

    typedef enum logic [1:0] {
        WB_RUN    = 2'd0,
        WB_HALTED = 2'd1,
        WB_FAULT  = 2'd2
    } wb_state_t;

endpackage

`default_nettype wire

// File: wb_redirect.sv
`timescale 1ns/1ns
`default_nettype none

`include "wb_params.svh"

module wb_redirect (
    input  logic                  accept,
    input  logic                  ld_eip_cs,
    input  wb_pkg::wb_data_u      op1,
    input  logic                  br_taken_in,
    input  logic                  br_correct_in,
    input  logic [`WB_ADDR_W-1:0] br_fip,
    input  logic [`WB_ADDR_W-1:0] br_fip_p1,
    input  logic [`WB_ADDR_W-1:0] eip_in,
    input  logic                  ie_in,
    input  logic                  interrupt_in,
    input  logic [`WB_IE_W-1:0]   ie_type_in,
    output logic [`WB_ADDR_W-1:0] new_fip_e,
    output logic [`WB_ADDR_W-1:0] new_fip_o,
    output logic [`WB_ADDR_W-1:0] new_eip,
    output logic                  is_resteer,
    output logic                  ie_val,
    output logic [`WB_IE_W-1:0]   ie_type
);

    logic [`WB_ADDR_W-1:0] line_a;      // 16-byte line of br_fip
    logic [`WB_ADDR_W-1:0] line_b;      // next line
    logic [`WB_ADDR_W-1:0] target;

    assign line_a = {br_fip[`WB_ADDR_W-1:4], 4'h0};
    assign line_b = {br_fip_p1[`WB_ADDR_W-1:4], 4'h0};

    // odd target line goes to the odd bank
    assign new_fip_e = br_fip[4] ? line_b : line_a;
    assign new_fip_o = br_fip[4] ? line_a : line_b;

    assign target  = ld_eip_cs ? op1.far.offset : br_fip;
    assign new_eip = br_taken_in ? target : eip_in;

    assign is_resteer = accept & ~br_correct_in;

    assign ie_val  = ie_in | interrupt_in;
    assign ie_type = {interrupt_in, ie_type_in[2:0]};   // bit 3 marks external int

endmodule

`default_nettype wire

// File: wb_route.sv
`timescale 1ns/1ns
`default_nettype none

`include "wb_params.svh"

module wb_route (
    input  logic                                       accept,
    input  wb_pkg::wb_operand_t [`WB_NUM_OPS-1:0]      ops,
    input  logic [`WB_SIZE_W-1:0]                      op_size,
    input  logic [3:0]                                 size_ovr,   // one-hot
    input  logic                                       ld_eip_cs,
    output logic [`WB_NUM_OPS-1:0]                     reg_ld,
    output logic [`WB_NUM_OPS-1:0]                     seg_ld,
    output logic [`WB_NUM_OPS*`WB_RID_W-1:0]           reg_addr,
    output logic [`WB_NUM_OPS*`WB_RID_W-1:0]           seg_addr,
    output logic [`WB_NUM_OPS-1:0][`WB_DATA_W-1:0]     res,
    output logic                                       mem_ld,
    output wb_pkg::wbaq_entry_t                        mem_wr
);

    logic [`WB_NUM_OPS-1:0] mem_cand;   // ignores accept
    logic [`WB_SIZE_W-1:0]  memsize;

    always_comb begin
        for (int k = 0; k < `WB_NUM_OPS; k++) begin
            reg_ld[k]   = ops[k].is_reg & ops[k].wb & accept;
            seg_ld[k]   = ops[k].is_seg & ops[k].wb & accept;
            mem_cand[k] = ops[k].is_mem & ops[k].wb;
            reg_addr[k*`WB_RID_W +: `WB_RID_W] = ops[k].dest[`WB_RID_W-1:0];
            seg_addr[k*`WB_RID_W +: `WB_RID_W] = ops[k].dest[`WB_RID_W-1:0];
            res[k] = ops[k].data.raw;
        end
        // far transfer puts the new cs selector on res1
        if (ld_eip_cs) begin
            res[0] = {{(`WB_DATA_W-16){1'b0}}, ops[0].data.far.sel};
        end
    end

    assign mem_ld = |mem_cand;

    // override index, else far pointer size, else normal size
    always_comb begin
        if (size_ovr[3]) begin
            memsize = 2'd3;
        end else if (size_ovr[2]) begin
            memsize = 2'd2;
        end else if (size_ovr[1]) begin
            memsize = 2'd1;
        end else if (size_ovr[0]) begin
            memsize = 2'd0;
        end else if (ld_eip_cs) begin
            memsize = 2'd3;
        end else begin
            memsize = op_size;
        end
    end

    always_comb begin
        mem_wr      = '0;
        mem_wr.size = memsize;
        for (int k = `WB_NUM_OPS - 1; k >= 0; k--) begin
            if (mem_cand[k]) begin              // lowest index wins
                mem_wr.addr = ops[k].dest;
                mem_wr.data = ops[k].data.raw;
            end
        end
    end

endmodule

`default_nettype wire

// File: wb_stage_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "wb_params.svh"

module wb_stage_tb;
    import wb_pkg::*;

    localparam int N     = `WB_NUM_OPS;
    localparam int LIMIT = 40;              // cycles allowed per wait

    typedef struct packed {
        logic [N-1:0]                 reg_ld;
        logic [N-1:0]                 seg_ld;
        logic [N*`WB_RID_W-1:0]       addr;       // same packing for reg and seg
        logic [`WB_SIZE_W-1:0]        memsize;
        logic [N-1:0][`WB_DATA_W-1:0] res;
        logic [`WB_ADDR_W-1:0]        fip_e;
        logic [`WB_ADDR_W-1:0]        fip_o;
        logic [`WB_ADDR_W-1:0]        eip;
        logic                         resteer;
        logic                         ie_val;
        logic [`WB_IE_W-1:0]          ie_type;
        logic                         mem_any;    // raw request ignoring accept
        wbaq_entry_t                  entry;
    } expect_t;

    logic clk, rst_n, valid_in, ld_eip_cs, is_halt, mem_ack, ie_ack;
    logic br_valid_in, br_taken_in, br_correct_in, ie_in, interrupt_in;
    logic valid_out, stall, halted, mem_ld, br_valid, is_resteer, ie_val, mem_req;
    wb_operand_t [N-1:0]          ops;
    logic [`WB_SIZE_W-1:0]        op_size, memsize;
    logic [3:0]                   size_ovr;
    logic [`WB_ADDR_W-1:0]        br_fip, br_fip_p1, eip_in;
    logic [`WB_ADDR_W-1:0]        new_fip_e, new_fip_o, new_eip;
    logic [`WB_IE_W-1:0]          ie_type_in, ie_type;
    wb_state_t                    state;
    logic [N-1:0]                 reg_ld, seg_ld;
    logic [N*`WB_RID_W-1:0]       reg_addr, seg_addr;
    logic [N-1:0][`WB_DATA_W-1:0] res;
    wbaq_entry_t                  mem_entry;

    logic [31:0] seed = 32'habad;
    int          err_val = 0;
    int          err_other = 0;
    int          n_accept = 0;
    int          n_pop = 0;
    bit          abort = 1'b0;
    bit          last_stall = 1'b0;
    wb_state_t   m_state = WB_RUN;
    wbaq_entry_t model_q[$];               // accepted writes with the oldest first

    tb_clk_gen #(.PERIOD(20)) clk_gen_i (.clk(clk));

    wb_stage_top dut_i (.*);

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic expect_t ref_outputs(input logic acc);
        expect_t e;
        logic    found;
        logic    ovr_hit;
        e       = '0;
        found   = 1'b0;
        ovr_hit = 1'b0;
        for (int k = 0; k < N; k++) begin
            e.reg_ld[k] = acc && ops[k].wb && ops[k].is_reg;
            e.seg_ld[k] = acc && ops[k].wb && ops[k].is_seg;
            e.addr[k*`WB_RID_W +: `WB_RID_W] = ops[k].dest[`WB_RID_W-1:0];
            e.res[k]    = ops[k].data.raw;
            if (ops[k].wb && ops[k].is_mem && !found) begin
                found        = 1'b1;            // first memory operand wins
                e.entry.addr = ops[k].dest;
                e.entry.data = ops[k].data.raw;
            end
        end
        for (int b = 0; b < 4; b++) begin
            if (size_ovr[b]) begin
                ovr_hit   = 1'b1;
                e.memsize = 2'(b);              // highest set bit survives
            end
        end
        if (!ovr_hit) begin
            e.memsize = ld_eip_cs ? 2'd3 : op_size;
        end
        e.mem_any    = found;
        e.entry.size = e.memsize;
        if (ld_eip_cs) begin
            e.res[0] = {48'h0, ops[0].data.raw[47:32]};
        end
        e.fip_e   = br_fip[4] ? {br_fip_p1[31:4], 4'h0} : {br_fip[31:4], 4'h0};
        e.fip_o   = br_fip[4] ? {br_fip[31:4], 4'h0} : {br_fip_p1[31:4], 4'h0};
        e.eip     = !br_taken_in ? eip_in : (ld_eip_cs ? ops[0].data.raw[31:0] : br_fip);
        e.resteer = acc && !br_correct_in;
        e.ie_val  = ie_in || interrupt_in;
        e.ie_type = {interrupt_in, ie_type_in[2:0]};
        return e;
    endfunction

    task automatic report_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        err_val++;
    endtask

    // all inputs except mem_ack and ie_ack
    task automatic drive_random(input logic mem_ok);
        logic [31:0] r;
        for (int k = 0; k < N; k++) begin
            r = lcg_next();
            ops[k].data.raw = {lcg_next(), lcg_next()};
            ops[k].dest     = lcg_next();
            ops[k].is_reg   = r[0];
            ops[k].is_seg   = r[1];
            ops[k].is_mem   = r[2] && r[3] && mem_ok;
            ops[k].wb       = r[4] || r[5];
        end
        r = lcg_next();
        valid_in      = r[0] || r[1] || r[2];
        op_size       = r[4:3];
        size_ovr      = r[5] ? (4'b0001 << r[7:6]) : 4'b0000;
        ld_eip_cs     = r[8] && r[9];
        br_valid_in   = r[10];
        br_taken_in   = r[11];
        br_correct_in = r[12] || r[13];
        ie_type_in    = r[17:14];
        br_fip        = lcg_next();
        br_fip_p1     = br_fip + 32'd16;
        eip_in        = lcg_next();
        is_halt       = 1'b0;
        ie_in         = 1'b0;
        interrupt_in  = 1'b0;
    endtask

    task automatic drive_mem_write();
        drive_random(1'b1);
        valid_in      = 1'b1;
        ops[1].is_mem = 1'b1;
        ops[1].wb     = 1'b1;
    endtask

    // waits for an empty queue when draining, otherwise for target acceptances
    task automatic wait_progress(input bit drain, input int target);
        int cycles = 0;
        while (!abort && (drain ? (mem_req !== 1'b0 || model_q.size() != 0)
                                : n_accept < target)) begin
            if (cycles == LIMIT) begin
                $display("ERROR at %0t ns: DUT timed out (drain %0d, accepted %0d of %0d)",
                         $time, drain, n_accept, target);
                err_other++;
                abort = 1'b1;
            end else begin
                @(negedge clk);
            end
            cycles++;
        end
    endtask

    always @(posedge clk) begin
        expect_t e;
        logic    full_m, stall_m, acc_m;
        if (!rst_n) begin
            model_q.delete();
            m_state    = WB_RUN;
            last_stall = 1'b0;
        end else begin
            full_m  = (model_q.size() == `WBAQ_DEPTH);
            e       = ref_outputs(1'b0);
            stall_m = (m_state == WB_RUN) && valid_in && e.mem_any && full_m;
            acc_m   = (m_state == WB_RUN) && valid_in && !stall_m;
            e       = ref_outputs(acc_m);
            if (stall !== stall_m) report_value("stall", 64'(stall), 64'(stall_m));
            if (valid_out !== acc_m) report_value("valid_out", 64'(valid_out), 64'(acc_m));
            if (state !== m_state) report_value("state", 64'(state), 64'(m_state));
            if (halted !== (m_state == WB_HALTED))
                report_value("halted", 64'(halted), 64'(m_state == WB_HALTED));
            if (mem_req !== (model_q.size() != 0))
                report_value("mem_req", 64'(mem_req), 64'(model_q.size() != 0));
            if (mem_ld !== (acc_m && e.mem_any))
                report_value("mem_ld", 64'(mem_ld), 64'(acc_m && e.mem_any));
            if (br_valid !== (br_valid_in && acc_m))
                report_value("br_valid", 64'(br_valid), 64'(br_valid_in && acc_m));
            if (reg_ld !== e.reg_ld) report_value("reg_ld", 64'(reg_ld), 64'(e.reg_ld));
            if (seg_ld !== e.seg_ld) report_value("seg_ld", 64'(seg_ld), 64'(e.seg_ld));
            if (reg_addr !== e.addr) report_value("reg_addr", 64'(reg_addr), 64'(e.addr));
            if (seg_addr !== e.addr) report_value("seg_addr", 64'(seg_addr), 64'(e.addr));
            if (memsize !== e.memsize) report_value("memsize", 64'(memsize), 64'(e.memsize));
            for (int k = 0; k < N; k++) begin
                if (res[k] !== e.res[k])
                    report_value($sformatf("res%0d", k + 1), res[k], e.res[k]);
            end
            if (new_fip_e !== e.fip_e) report_value("new_fip_e", 64'(new_fip_e), 64'(e.fip_e));
            if (new_fip_o !== e.fip_o) report_value("new_fip_o", 64'(new_fip_o), 64'(e.fip_o));
            if (new_eip !== e.eip) report_value("new_eip", 64'(new_eip), 64'(e.eip));
            if (is_resteer !== e.resteer)
                report_value("is_resteer", 64'(is_resteer), 64'(e.resteer));
            if (ie_val !== e.ie_val) report_value("ie_val", 64'(ie_val), 64'(e.ie_val));
            if (ie_type !== e.ie_type) report_value("ie_type", 64'(ie_type), 64'(e.ie_type));
            if (model_q.size() != 0 && mem_ack) begin
                if (mem_entry.addr !== model_q[0].addr)
                    report_value("mem_entry.addr", 64'(mem_entry.addr), 64'(model_q[0].addr));
                if (mem_entry.data !== model_q[0].data)
                    report_value("mem_entry.data", mem_entry.data, model_q[0].data);
                if (mem_entry.size !== model_q[0].size)
                    report_value("mem_entry.size", 64'(mem_entry.size), 64'(model_q[0].size));
                void'(model_q.pop_front());
                n_pop++;
            end
            if (acc_m && e.mem_any) begin
                model_q.push_back(e.entry);
            end
            if (m_state == WB_RUN && acc_m && e.ie_val) begin
                m_state = WB_FAULT;
            end else if (m_state == WB_RUN && acc_m && is_halt) begin
                m_state = WB_HALTED;
            end else if (m_state == WB_FAULT && ie_ack) begin
                m_state = WB_RUN;
            end
            if (valid_out === 1'b1) begin
                n_accept++;
            end
            last_stall = stall_m;
        end
    end

    initial begin
        logic [31:0] r;
        int          base;
        rst_n   = 1'b0;
        mem_ack = 1'b0;
        ie_ack  = 1'b0;
        drive_random(1'b0);
        valid_in = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // random traffic with inputs held while stalled
        for (int i = 0; i < 300; i++) begin
            if (!last_stall) begin
                drive_random(1'b1);
            end
            r       = lcg_next();
            mem_ack = r[0];
            @(negedge clk);
        end
        valid_in = 1'b0;
        mem_ack  = 1'b1;
        wait_progress(1'b1, 0);

        // four writes fill the queue and the fifth waits for an ack
        mem_ack = 1'b0;
        base    = n_accept;
        for (int i = 1; i <= `WBAQ_DEPTH; i++) begin
            drive_mem_write();
            wait_progress(1'b0, base + i);
        end
        drive_mem_write();
        #5;
        if (stall !== 1'b1) report_value("stall", 64'(stall), 64'd1);
        if (valid_out !== 1'b0) report_value("valid_out", 64'(valid_out), 64'd0);
        @(negedge clk);
        mem_ack = 1'b1;
        @(negedge clk);
        mem_ack = 1'b0;
        wait_progress(1'b0, base + `WBAQ_DEPTH + 1);
        valid_in = 1'b0;
        mem_ack  = 1'b1;
        wait_progress(1'b1, 0);

        // external interrupt blocks the stage until ie_ack
        base = n_accept;
        drive_random(1'b0);
        valid_in     = 1'b1;
        interrupt_in = 1'b1;
        wait_progress(1'b0, base + 1);
        drive_random(1'b0);
        valid_in = 1'b1;
        repeat (3) begin
            #5;
            if (valid_out !== 1'b0) report_value("valid_out", 64'(valid_out), 64'd0);
            @(negedge clk);
        end
        ie_ack = 1'b1;
        @(negedge clk);
        ie_ack = 1'b0;
        wait_progress(1'b0, base + 2);

        // internal exception takes the same fault path
        base = n_accept;
        drive_random(1'b0);
        valid_in = 1'b1;
        ie_in    = 1'b1;
        wait_progress(1'b0, base + 1);
        valid_in = 1'b0;
        ie_in    = 1'b0;
        ie_ack   = 1'b1;
        @(negedge clk);
        ie_ack = 1'b0;

        // halt with two writes still queued
        mem_ack = 1'b0;
        base    = n_accept;
        drive_mem_write();
        wait_progress(1'b0, base + 1);
        drive_mem_write();
        wait_progress(1'b0, base + 2);
        drive_random(1'b0);
        valid_in = 1'b1;
        is_halt  = 1'b1;
        wait_progress(1'b0, base + 3);
        drive_mem_write();
        mem_ack = 1'b1;
        repeat (4) begin
            #5;
            if (halted !== 1'b1) report_value("halted", 64'(halted), 64'd1);
            if (valid_out !== 1'b0) report_value("valid_out", 64'(valid_out), 64'd0);
            if ({reg_ld, seg_ld, mem_ld} !== '0)
                report_value("load strobes", 64'({reg_ld, seg_ld, mem_ld}), 64'd0);
            @(negedge clk);
        end
        wait_progress(1'b1, 0);

        $display("summary: %0d value errors, %0d other errors, %0d accepted, %0d writes drained",
                 err_val, err_other, n_accept, n_pop);
        if (err_val == 0 && err_other == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: wb_stage_top.f
+incdir+.
wb_pkg.sv
wb_ctrl.sv
wbaq_count.sv
wbaq_buffer.sv
wb_route.sv
wb_redirect.sv
wb_stage_top.sv
tb_clk_gen.sv
wb_stage_tb.sv

// File: wb_stage_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "wb_params.svh"

module wb_stage_top (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   valid_in,
    input  wb_pkg::wb_operand_t [`WB_NUM_OPS-1:0]  ops,
    input  logic [`WB_SIZE_W-1:0]                  op_size,
    input  logic [3:0]                             size_ovr,
    input  logic                                   ld_eip_cs,
    input  logic                                   is_halt,
    input  logic                                   br_valid_in,
    input  logic                                   br_taken_in,
    input  logic                                   br_correct_in,
    input  logic [`WB_ADDR_W-1:0]                  br_fip,
    input  logic [`WB_ADDR_W-1:0]                  br_fip_p1,
    input  logic [`WB_ADDR_W-1:0]                  eip_in,
    input  logic                                   ie_in,
    input  logic [`WB_IE_W-1:0]                    ie_type_in,
    input  logic                                   interrupt_in,
    input  logic                                   mem_ack,
    input  logic                                   ie_ack,
    output logic                                   valid_out,
    output logic                                   stall,
    output logic                                   halted,
    output wb_pkg::wb_state_t                      state,
    output logic [`WB_NUM_OPS-1:0]                 reg_ld,
    output logic [`WB_NUM_OPS-1:0]                 seg_ld,
    output logic [`WB_NUM_OPS*`WB_RID_W-1:0]       reg_addr,
    output logic [`WB_NUM_OPS*`WB_RID_W-1:0]       seg_addr,
    output logic [`WB_NUM_OPS-1:0][`WB_DATA_W-1:0] res,
    output logic [`WB_SIZE_W-1:0]                  memsize,
    output logic                                   mem_ld,
    output logic [`WB_ADDR_W-1:0]                  new_fip_e,
    output logic [`WB_ADDR_W-1:0]                  new_fip_o,
    output logic [`WB_ADDR_W-1:0]                  new_eip,
    output logic                                   br_valid,
    output logic                                   is_resteer,
    output logic                                   ie_val,
    output logic [`WB_IE_W-1:0]                    ie_type,
    output logic                                   mem_req,
    output wb_pkg::wbaq_entry_t                    mem_entry
);
    import wb_pkg::*;

    logic        accept;
    logic        mem_ld_raw;
    logic        full;
    logic        empty;
    logic        pop;
    wbaq_entry_t mem_wr;

    assign valid_out = accept;
    assign mem_ld    = accept & mem_ld_raw;     // queue push
    assign mem_req   = ~empty;
    assign pop       = mem_req & mem_ack;
    assign memsize   = mem_wr.size;
    assign br_valid  = br_valid_in & accept;

    wb_ctrl u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid_in (valid_in),
        .mem_ld   (mem_ld_raw),
        .full     (full),
        .is_halt  (is_halt),
        .ie_val   (ie_val),
        .ie_ack   (ie_ack),
        .stall    (stall),
        .accept   (accept),
        .halted   (halted),
        .state    (state)
    );

    wbaq_count u_count (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (mem_ld),
        .pop   (pop),
        .full  (full),
        .empty (empty)
    );

    wbaq_buffer u_buffer (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (mem_ld),
        .pop      (pop),
        .wr_entry (mem_wr),
        .head     (mem_entry)
    );

    wb_route u_route (
        .accept    (accept),
        .ops       (ops),
        .op_size   (op_size),
        .size_ovr  (size_ovr),
        .ld_eip_cs (ld_eip_cs),
        .reg_ld    (reg_ld),
        .seg_ld    (seg_ld),
        .reg_addr  (reg_addr),
        .seg_addr  (seg_addr),
        .res       (res),
        .mem_ld    (mem_ld_raw),
        .mem_wr    (mem_wr)
    );

    wb_redirect u_redirect (
        .accept        (accept),
        .ld_eip_cs     (ld_eip_cs),
        .op1           (ops[0].data),
        .br_taken_in   (br_taken_in),
        .br_correct_in (br_correct_in),
        .br_fip        (br_fip),
        .br_fip_p1     (br_fip_p1),
        .eip_in        (eip_in),
        .ie_in         (ie_in),
        .interrupt_in  (interrupt_in),
        .ie_type_in    (ie_type_in),
        .new_fip_e     (new_fip_e),
        .new_fip_o     (new_fip_o),
        .new_eip       (new_eip),
        .is_resteer    (is_resteer),
        .ie_val        (ie_val),
        .ie_type       (ie_type)
    );

endmodule

`default_nettype wire

// File: wbaq_buffer.sv
`timescale 1ns/1ns
`default_nettype none

`include "wb_params.svh"

module wbaq_buffer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                push,
    input  logic                pop,
    input  wb_pkg::wbaq_entry_t wr_entry,
    output wb_pkg::wbaq_entry_t head
);
    import wb_pkg::*;

    wbaq_entry_t             mem [`WBAQ_DEPTH];
    logic [`WBAQ_PTR_W-1:0]  wr_ptr;
    logic [`WBAQ_PTR_W-1:0]  rd_ptr;

    // pointers wrap on their own as depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_entry;
        end
    end

    assign head = mem[rd_ptr];

endmodule

`default_nettype wire

// File: wbaq_count.sv
`timescale 1ns/1ns
`default_nettype none

`include "wb_params.svh"

module wbaq_count (
    input  logic clk,
    input  logic rst_n,
    input  logic push,
    input  logic pop,
    output logic full,
    output logic empty
);

    localparam int CNT_W = `WBAQ_PTR_W + 1;

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (push && !pop) begin
            count <= count + 1'b1;
        end else if (pop && !push) begin
            count <= count - 1'b1;
        end
    end

    assign full  = (count == CNT_W'(`WBAQ_DEPTH));
    assign empty = (count == '0);

endmodule

`default_nettype wire
